// ==== hdl/mul_cfg_pkg.sv ====
/*
  Sizes of the vector multiply unit.
  The top level picks VLEN from here and passes it down; lanes are fixed at LANE_W.
*/
package mul_cfg_pkg;

  ////////////////////////////////////////
  // scalar and tag widths
  ////////////////////////////////////////
  localparam int XLEN      = 32;  // rs1 width
  localparam int ROB_TAG_W = 4;   // rob entry index

  ////////////////////////////////////////
  // lane geometry
  ////////////////////////////////////////
  localparam int LANE_W         = 32;               // one lane = one eew32 element
  localparam int BYTE_W         = 8;                // partial product input
  localparam int BYTES_PER_LANE = LANE_W / BYTE_W;  // 4x4 byte grid per lane

  // must stay a multiple of LANE_W
  localparam int VLEN_DEFAULT = 128;

endpackage

// ==== hdl/mul_op_pkg.sv ====
/*
  Encodings used by the vector multiply unit.
  funct3 categories and funct6 opcodes follow the RISC-V vector spec.
*/
package mul_op_pkg;

  ////////////////////////////////////////
  // funct3 operand categories
  ////////////////////////////////////////
  typedef enum logic [2:0] {
    OPIVV = 3'b000,
    OPMVV = 3'b010,  // vector-vector
    OPIVX = 3'b100,
    OPMVX = 3'b110   // vector-scalar, rs1 splat
  } op_cat_e;

  ////////////////////////////////////////
  // funct6 multiply opcodes
  ////////////////////////////////////////
  typedef enum logic [5:0] {
    VMULHU  = 6'b100100,
    VMUL    = 6'b100101,
    VMULHSU = 6'b100110,
    VMULH   = 6'b100111
  } mul_funct6_e;

  // element width, 2'b11 is handled as EEW8
  typedef enum logic [1:0] {
    EEW8  = 2'b00,
    EEW16 = 2'b01,
    EEW32 = 2'b10
  } eew_e;

  // request FSM in the operand stage
  typedef enum logic [1:0] {
    IDLE     = 2'b00,
    EXEC     = 2'b01,
    ACK_WAIT = 2'b10
  } prep_state_e;

endpackage

// ==== hdl/mul_operand_prep.sv ====
/*
  Front stage of the vector multiply unit.
  Runs the four-phase req/ack FSM, decodes funct3/funct6, captures the operands
  and splats rs1 for OPMVX. The captured values feed every lane until the next request.
*/
`timescale 1ns/1ns

module mul_operand_prep #(
  parameter int VLEN = mul_cfg_pkg::VLEN_DEFAULT
) (
  input  logic                              clk,
  input  logic                              arst_n,
  input  logic                              req,
  input  mul_op_pkg::op_cat_e               funct3,
  input  logic [5:0]                        funct6,
  input  mul_op_pkg::eew_e                  eew,
  input  logic [VLEN-1:0]                   vs1_data,
  input  logic [VLEN-1:0]                   vs2_data,
  input  logic [mul_cfg_pkg::XLEN-1:0]      rs1_data,
  input  logic [mul_cfg_pkg::ROB_TAG_W-1:0] rob_tag,
  input  logic                              done,
  output logic                              ack,
  output logic                              launch,
  output logic [VLEN-1:0]                   op_a,
  output logic [VLEN-1:0]                   op_b,
  output logic                              a_signed,
  output logic                              b_signed,
  output mul_op_pkg::eew_e                  eew_q,
  output logic                              keep_low,
  output logic [mul_cfg_pkg::ROB_TAG_W-1:0] result_tag
);
  import mul_cfg_pkg::*;
  import mul_op_pkg::*;

  prep_state_e state;
  logic        accept;
  mul_funct6_e dec_op;
  logic        is_vx;
  logic        dec_a_signed;
  logic        dec_b_signed;
  logic        dec_keep_low;
  logic [VLEN-1:0] splat_b;

  ////////////////////////////////////////
  // decode
  ////////////////////////////////////////
  assign accept = (state == IDLE) && req;

  always_comb begin
    dec_op = mul_funct6_e'(funct6);
    is_vx  = (funct3 == OPMVX);
    if (!(funct3 inside {OPMVV, OPMVX})) begin
      dec_op = VMUL;  // other categories run as vmul.vv
    end
    case (dec_op)
      VMULH: begin
        dec_a_signed = 1'b1;
        dec_b_signed = 1'b1;
        dec_keep_low = 1'b0;
      end
      VMULHU: begin
        dec_a_signed = 1'b0;
        dec_b_signed = 1'b0;
        dec_keep_low = 1'b0;
      end
      VMULHSU: begin
        dec_a_signed = 1'b1;  // vs2 signed
        dec_b_signed = 1'b0;  // vs1 / rs1 unsigned
        dec_keep_low = 1'b0;
      end
      default: begin  // VMUL and any unknown funct6
        dec_a_signed = 1'b1;
        dec_b_signed = 1'b1;
        dec_keep_low = 1'b1;
      end
    endcase
  end

  // rs1 replicated at element width, upper bits dropped
  always_comb begin
    case (eew)
      EEW16:   splat_b = {(VLEN/16){rs1_data[15:0]}};
      EEW32:   splat_b = {(VLEN/32){rs1_data[31:0]}};
      default: splat_b = {(VLEN/8){rs1_data[7:0]}};
    endcase
  end

  ////////////////////////////////////////
  // capture
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (accept) begin
      op_a       <= vs2_data;
      op_b       <= is_vx ? splat_b : vs1_data;
      result_tag <= rob_tag;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      a_signed <= 1'b0;
      b_signed <= 1'b0;
      keep_low <= 1'b0;
      eew_q    <= EEW8;
    end else if (accept) begin
      a_signed <= dec_a_signed;
      b_signed <= dec_b_signed;
      keep_low <= dec_keep_low;
      eew_q    <= eew;
    end
  end

  ////////////////////////////////////////
  // handshake FSM
  ////////////////////////////////////////
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state  <= IDLE;
      ack    <= 1'b0;
      launch <= 1'b0;
    end else begin
      launch <= 1'b0;  // single cycle pulse
      case (state)
        IDLE: begin
          if (req) begin
            state  <= EXEC;
            launch <= 1'b1;
          end
        end
        EXEC: begin
          if (done) begin
            state <= ACK_WAIT;
            ack   <= 1'b1;
          end
        end
        ACK_WAIT: begin
          if (!req) begin  // phase 3 seen, close the transfer
            state <= IDLE;
            ack   <= 1'b0;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

endmodule

// ==== hdl/mul_lane.sv ====
/*
  One 32-bit multiply lane built from a 4x4 grid of byte products.
  Products are registered on launch, then summed per element width and the
  low or high half of each element product is selected.
*/
`timescale 1ns/1ns

module mul_lane (
  input  logic                           clk,
  input  logic                           arst_n,
  input  logic                           launch,
  input  logic [mul_cfg_pkg::LANE_W-1:0] op_a,
  input  logic [mul_cfg_pkg::LANE_W-1:0] op_b,
  input  logic                           a_signed,
  input  logic                           b_signed,
  input  mul_op_pkg::eew_e               eew,
  input  logic                           keep_low,
  output logic [mul_cfg_pkg::LANE_W-1:0] lane_result
);
  import mul_cfg_pkg::*;
  import mul_op_pkg::*;

  // a 9x9 signed product always fits in 17 bits
  localparam int PROD_W = 2*BYTE_W + 1;

  logic [BYTES_PER_LANE-1:0] top_byte;
  logic signed [BYTE_W:0]    ext_a [BYTES_PER_LANE];
  logic signed [BYTE_W:0]    ext_b [BYTES_PER_LANE];
  logic signed [PROD_W-1:0]  prod_d [BYTES_PER_LANE][BYTES_PER_LANE];
  logic signed [PROD_W-1:0]  prod_q [BYTES_PER_LANE][BYTES_PER_LANE];
  logic [15:0]               full_e8 [4];
  logic [31:0]               full_e16 [2];
  logic [63:0]               full_e32;

  ////////////////////////////////////////
  // byte grid
  ////////////////////////////////////////
  always_comb begin
    case (eew)
      EEW16:   top_byte = 4'b1010;
      EEW32:   top_byte = 4'b1000;
      default: top_byte = 4'b1111;  // every byte is an element
    endcase
    // only the top byte of an element carries the sign
    for (int i = 0; i < BYTES_PER_LANE; i++) begin
      ext_a[i] = {a_signed & top_byte[i] & op_a[i*BYTE_W + BYTE_W-1],
                  op_a[i*BYTE_W +: BYTE_W]};
      ext_b[i] = {b_signed & top_byte[i] & op_b[i*BYTE_W + BYTE_W-1],
                  op_b[i*BYTE_W +: BYTE_W]};
    end
    for (int i = 0; i < BYTES_PER_LANE; i++) begin
      for (int j = 0; j < BYTES_PER_LANE; j++) begin
        prod_d[i][j] = ext_a[i] * ext_b[j];
      end
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      prod_q <= '{default: '0};
    end else if (launch) begin
      prod_q <= prod_d;
    end
  end

  ////////////////////////////////////////
  // partial product sums
  ////////////////////////////////////////
  always_comb begin
    // eew8: diagonal products are already complete
    for (int e = 0; e < 4; e++) begin
      full_e8[e] = prod_q[e][e][15:0];
    end

    // eew16: 2x2 block per element
    for (int e = 0; e < 2; e++) begin
      full_e16[e] = '0;
      for (int i = 2*e; i < 2*e + 2; i++) begin
        for (int j = 2*e; j < 2*e + 2; j++) begin
          full_e16[e] = full_e16[e] +
                        ({{(32-PROD_W){prod_q[i][j][PROD_W-1]}}, prod_q[i][j]}
                         << (BYTE_W*(i + j - 4*e)));
        end
      end
    end

    // eew32: all sixteen products
    full_e32 = '0;
    for (int i = 0; i < BYTES_PER_LANE; i++) begin
      for (int j = 0; j < BYTES_PER_LANE; j++) begin
        full_e32 = full_e32 +
                   ({{(64-PROD_W){prod_q[i][j][PROD_W-1]}}, prod_q[i][j]}
                    << (BYTE_W*(i + j)));
      end
    end
  end

  ////////////////////////////////////////
  // half select
  ////////////////////////////////////////
  always_comb begin
    case (eew)
      EEW16: begin
        for (int e = 0; e < 2; e++) begin
          lane_result[16*e +: 16] = keep_low ? full_e16[e][15:0] : full_e16[e][31:16];
        end
      end
      EEW32: begin
        lane_result = keep_low ? full_e32[31:0] : full_e32[63:32];
      end
      default: begin
        for (int e = 0; e < 4; e++) begin
          lane_result[8*e +: 8] = keep_low ? full_e8[e][7:0] : full_e8[e][15:8];
        end
      end
    endcase
  end

endmodule

// ==== hdl/mul_result_collect.sv ====
/*
  Output stage of the vector multiply unit.
  Latches the concatenated lane results one edge after the lane products
  settle and pulses done back to the request FSM.
*/
`timescale 1ns/1ns

module mul_result_collect #(
  parameter int VLEN = mul_cfg_pkg::VLEN_DEFAULT
) (
  input  logic            clk,
  input  logic            arst_n,
  input  logic            launch,
  input  logic [VLEN-1:0] lane_results,
  output logic [VLEN-1:0] result,
  output logic            done
);

  logic launch_q;  // lane products valid while high

  ////////////////////////////////////////
  // result register
  ////////////////////////////////////////
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      launch_q <= 1'b0;
      done     <= 1'b0;
      result   <= '0;
    end else begin
      launch_q <= launch;
      done     <= launch_q;  // one cycle, lines up with result
      if (launch_q) begin
        result <= lane_results;  // held until the next operation
      end
    end
  end

endmodule

// ==== hdl/vec_mul_unit.sv ====
/*
  Vector integer multiply unit, VMUL/VMULH/VMULHU/VMULHSU at eew 8/16/32.
  One operation per four-phase req/ack transfer; result and tag are valid
  while ack is high. VLEN must be a multiple of the lane width.
*/
`timescale 1ns/1ns

module vec_mul_unit #(
  parameter int VLEN = mul_cfg_pkg::VLEN_DEFAULT
) (
  input  logic                              clk,
  input  logic                              arst_n,
  input  logic                              req,
  input  mul_op_pkg::op_cat_e               funct3,
  input  logic [5:0]                        funct6,
  input  mul_op_pkg::eew_e                  eew,
  input  logic [VLEN-1:0]                   vs1_data,
  input  logic [VLEN-1:0]                   vs2_data,
  input  logic [mul_cfg_pkg::XLEN-1:0]      rs1_data,
  input  logic [mul_cfg_pkg::ROB_TAG_W-1:0] rob_tag,
  output logic                              ack,
  output logic [VLEN-1:0]                   result,
  output logic [mul_cfg_pkg::ROB_TAG_W-1:0] result_tag
);
  import mul_cfg_pkg::*;
  import mul_op_pkg::*;

  localparam int NUM_LANES = VLEN / LANE_W;

  logic            launch;
  logic            done;
  logic [VLEN-1:0] op_a;
  logic [VLEN-1:0] op_b;
  logic            a_signed;
  logic            b_signed;
  eew_e            lane_eew;
  logic            keep_low;
  logic [VLEN-1:0] lane_results;

  ////////////////////////////////////////
  // operand stage
  ////////////////////////////////////////
  mul_operand_prep #(.VLEN(VLEN)) mul_operand_prep_i (
    .clk        (clk),
    .arst_n     (arst_n),
    .req        (req),
    .funct3     (funct3),
    .funct6     (funct6),
    .eew        (eew),
    .vs1_data   (vs1_data),
    .vs2_data   (vs2_data),
    .rs1_data   (rs1_data),
    .rob_tag    (rob_tag),
    .done       (done),
    .ack        (ack),
    .launch     (launch),
    .op_a       (op_a),
    .op_b       (op_b),
    .a_signed   (a_signed),
    .b_signed   (b_signed),
    .eew_q      (lane_eew),
    .keep_low   (keep_low),
    .result_tag (result_tag)
  );

  ////////////////////////////////////////
  // lanes
  ////////////////////////////////////////
  for (genvar l = 0; l < NUM_LANES; l++) begin : g_lane
    mul_lane mul_lane_i (
      .clk         (clk),
      .arst_n      (arst_n),
      .launch      (launch),
      .op_a        (op_a[l*LANE_W +: LANE_W]),
      .op_b        (op_b[l*LANE_W +: LANE_W]),
      .a_signed    (a_signed),
      .b_signed    (b_signed),
      .eew         (lane_eew),
      .keep_low    (keep_low),
      .lane_result (lane_results[l*LANE_W +: LANE_W])
    );
  end

  mul_result_collect #(.VLEN(VLEN)) mul_result_collect_i (
    .clk          (clk),
    .arst_n       (arst_n),
    .launch       (launch),
    .lane_results (lane_results),
    .result       (result),
    .done         (done)
  );

endmodule

// ==== sim/vec_mul_unit_props.sv ====
/*
  Handshake assertions for the vector multiply unit.
  Bound into every vec_mul_unit instance and watches only its ports.
*/
`timescale 1ns/1ns

module vec_mul_unit_props #(
  parameter int VLEN = mul_cfg_pkg::VLEN_DEFAULT
) (
  input logic                              clk,
  input logic                              arst_n,
  input logic                              req,
  input logic                              ack,
  input logic [VLEN-1:0]                   result,
  input logic [mul_cfg_pkg::ROB_TAG_W-1:0] result_tag
);

  int prop_errs = 0;  // failed assertions so far

  ack_needs_req: assert property (@(posedge clk) disable iff (!arst_n)
    $rose(ack) |-> $past(req))
    else begin
      $error("ack rose without a pending request");
      prop_errs++;
    end

  // ack sampled low for three edges after acceptance and high on the fourth
  ack_latency: assert property (@(posedge clk) disable iff (!arst_n)
    $rose(req) && !ack |=> !ack [*3] ##1 ack)
    else begin
      $error("ack did not rise three edges after acceptance");
      prop_errs++;
    end

  result_held: assert property (@(posedge clk) disable iff (!arst_n)
    ack && $past(ack) |-> $stable(result) && $stable(result_tag))
    else begin
      $error("result or result_tag changed while ack was high");
      prop_errs++;
    end

  ack_release: assert property (@(posedge clk) disable iff (!arst_n)
    ack && !req |=> !ack)
    else begin
      $error("ack still high one edge after req was seen low");
      prop_errs++;
    end

endmodule

bind vec_mul_unit vec_mul_unit_props #(.VLEN(VLEN)) vec_mul_unit_props_i (
  .clk        (clk),
  .arst_n     (arst_n),
  .req        (req),
  .ack        (ack),
  .result     (result),
  .result_tag (result_tag)
);

// ==== sim/vec_mul_unit_tb.sv ====
/*
  Testbench for the vector multiply unit.
  Runs four-phase transfers over every opcode, eew and operand form and checks
  result, tag and handshake timing against a per-element reference model.
*/
`timescale 1ns/1ns

module vec_mul_unit_tb;
  import mul_cfg_pkg::*;
  import mul_op_pkg::*;

  localparam int VLEN    = VLEN_DEFAULT;
  localparam int NUM_TXN = 4*3*4 + 4*3*2 + 3*2;
  localparam int MAX_CYC = NUM_TXN*12 + 100;

  logic                 clk = 1'b0;
  logic                 arst_n;
  logic                 req;
  op_cat_e              funct3;
  logic [5:0]           funct6;
  eew_e                 eew;
  logic [VLEN-1:0]      vs1_data;
  logic [VLEN-1:0]      vs2_data;
  logic [XLEN-1:0]      rs1_data;
  logic [ROB_TAG_W-1:0] rob_tag;
  logic                 ack;
  logic [VLEN-1:0]      result;
  logic [ROB_TAG_W-1:0] result_tag;

  integer               seed = 32'h4aee;
  int                   cycles = 0;
  int                   checks = 0;
  int                   value_errs = 0;
  int                   hs_errs = 0;
  int                   assert_errs = 0;
  logic [VLEN-1:0]      exp_result;
  logic [ROB_TAG_W-1:0] exp_tag;
  string                test_name;
  logic                 pending = 1'b0;  // a request is waiting for ack
  logic                 ack_seen = 1'b0;
  mul_funct6_e          ops [4] = '{VMUL, VMULH, VMULHU, VMULHSU};
  int                   a_kind [4] = '{0, 3, 1, 2};  // random, mix, all min, all ones
  int                   b_kind [4] = '{0, 4, 1, 1};

  always #4 clk = ~clk;

  vec_mul_unit vec_mul_unit_i (.*);

  always @(posedge clk) begin
    cycles++;
    if (cycles >= MAX_CYC) begin
      $display("timeout: run did not finish within %0d cycles", MAX_CYC);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  ////////////////////////////////////////
  // reference model
  ////////////////////////////////////////
  function automatic logic [VLEN-1:0] expected_product(
    op_cat_e cat, logic [5:0] f6, eew_e ew,
    logic [VLEN-1:0] vs1, logic [VLEN-1:0] vs2, logic [XLEN-1:0] rs1);
    int              sew;
    logic            a_sg;
    logic            b_sg;
    logic            low;
    logic [63:0]     mask;
    logic [63:0]     a;
    logic [63:0]     b;
    logic [63:0]     p;
    logic [VLEN-1:0] acc;
    if (!(cat inside {OPMVV, OPMVX})) f6 = VMUL;  // other categories run as vmul
    a_sg = (f6 != VMULHU);
    b_sg = !(f6 inside {VMULHU, VMULHSU});
    low  = !(f6 inside {VMULH, VMULHU, VMULHSU});
    sew  = (ew == EEW16) ? 16 : (ew == EEW32) ? 32 : 8;
    mask = (64'd1 << sew) - 1;
    acc  = '0;
    for (int e = 0; e < VLEN/sew; e++) begin
      a = 64'(vs2 >> (e*sew)) & mask;
      b = ((cat == OPMVX) ? 64'(rs1) : 64'(vs1 >> (e*sew))) & mask;
      if (a_sg && a[sew-1]) a = a | ~mask;
      if (b_sg && b[sew-1]) b = b | ~mask;
      p   = a * b;  // full product fits in 64 bits for any sign mix
      p   = low ? p : p >> sew;
      acc = acc | (VLEN'(p & mask) << (e*sew));
    end
    return acc;
  endfunction

  // kind 0 random, 1 all min, 2 all ones, 3/4 rotating 0 -1 min max
  task automatic make_operand(input eew_e ew, input int kind, output logic [VLEN-1:0] v);
    int          sew;
    int          sel;
    logic [63:0] el;
    sew = 8 << ew;
    for (int i = 0; i < VLEN/32; i++) begin
      v[32*i +: 32] = $random(seed);
    end
    if (kind != 0) begin
      v = '0;
      for (int e = 0; e < VLEN/sew; e++) begin
        sel = (kind == 1) ? 2 : (kind == 2) ? 1 : (e + kind) % 4;
        case (sel)
          1:       el = ~64'd0;
          2:       el = 64'd1 << (sew-1);
          3:       el = (64'd1 << (sew-1)) - 1;
          default: el = 64'd0;
        endcase
        v = v | (VLEN'(el & ((64'd1 << sew) - 1)) << (e*sew));
      end
    end
  endtask

  ////////////////////////////////////////
  // one four-phase transfer
  ////////////////////////////////////////
  task automatic run_txn(input op_cat_e cat, input logic [5:0] f6, input eew_e ew,
                         input logic [VLEN-1:0] v1, input logic [VLEN-1:0] v2,
                         input logic [XLEN-1:0] r1, input string name);
    int              lat;
    int              hold;
    logic [VLEN-1:0] held;
    logic [VLEN-1:0] junk;
    exp_result = expected_product(cat, f6, ew, v1, v2, r1);
    exp_tag    = ROB_TAG_W'($random(seed));
    test_name  = name;
    funct3     = cat;
    funct6     = f6;
    eew        = ew;
    vs1_data   = v1;
    vs2_data   = v2;
    rs1_data   = r1;
    rob_tag    = exp_tag;
    pending    = 1'b1;
    req        = 1'b1;
    lat        = 0;
    do begin
      @(negedge clk);
      lat++;
      if (lat == 1) begin  // accepted by now so the fields must be ignored
        make_operand(ew, 0, junk);
        vs1_data = junk;
        vs2_data = ~junk;
        rs1_data = $random(seed);
        rob_tag  = ~exp_tag;
      end
    end while (!ack);
    checks++;
    // third rising edge after acceptance shows at the fourth falling edge
    assert (lat == 4) else begin
      $display("ERROR %s: ack latency expected 4 actual %0d", name, lat);
      hs_errs++;
    end
    held = result;
    hold = $unsigned($random(seed)) % 6;
    repeat (hold) begin
      @(negedge clk);
      checks++;
      assert (ack === 1'b1 && result === held) else begin
        $display("%s: ack or result changed while req was still high", name);
        hs_errs++;
      end
    end
    req = 1'b0;
    @(negedge clk);
    checks++;
    assert (ack === 1'b0) else begin
      $display("%s: ack still high one edge after req dropped", name);
      hs_errs++;
    end
  endtask

  // compares on the first falling edge with ack high
  always @(negedge clk) begin
    if (arst_n && ack && !ack_seen) begin
      checks++;
      assert (pending) else begin
        $display("ack rose while no request was outstanding");
        hs_errs++;
      end
      assert (result === exp_result) else begin
        $display("ERROR %s: result expected %h actual %h", test_name, exp_result, result);
        value_errs++;
      end
      assert (result_tag === exp_tag) else begin
        $display("ERROR %s: result_tag expected %h actual %h", test_name, exp_tag, result_tag);
        value_errs++;
      end
      pending = 1'b0;
    end
    ack_seen = ack;
  end

  ////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////
  initial begin
    logic [VLEN-1:0] a;
    logic [VLEN-1:0] b;
    logic [XLEN-1:0] r;
    arst_n   = 1'b0;
    req      = 1'b0;
    funct3   = OPMVV;
    funct6   = VMUL;
    eew      = EEW8;
    vs1_data = '0;
    vs2_data = '0;
    rs1_data = '0;
    rob_tag  = '0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
    @(negedge clk);
    checks++;
    assert (ack === 1'b0) else begin
      $display("ack is high after reset with no request");
      hs_errs++;
    end
    assert (result === '0) else begin
      $display("ERROR reset: result expected 0 actual %h", result);
      value_errs++;
    end
    foreach (ops[o]) begin
      for (int w = 0; w < 3; w++) begin
        for (int k = 0; k < 4; k++) begin
          make_operand(eew_e'(w), a_kind[k], a);
          make_operand(eew_e'(w), b_kind[k], b);
          run_txn(OPMVV, ops[o], eew_e'(w), b, a, '0,
                  $sformatf("%s.vv eew%0d case%0d", ops[o].name(), 8 << w, k));
        end
        for (int k = 0; k < 2; k++) begin
          make_operand(eew_e'(w), k*3, a);
          make_operand(eew_e'(w), 0, b);  // vs1 unused in vx form
          r = $random(seed);
          if (k == 1) begin  // most negative element with random upper bits kept
            r = ((r >> (8 << w)) << (8 << w)) | (XLEN'(1) << ((8 << w) - 1));
          end
          run_txn(OPMVX, ops[o], eew_e'(w), b, a, r,
                  $sformatf("%s.vx eew%0d case%0d", ops[o].name(), 8 << w, k));
        end
      end
    end
    for (int w = 0; w < 3; w++) begin
      make_operand(eew_e'(w), 0, a);
      make_operand(eew_e'(w), 0, b);
      run_txn(OPMVV, 6'b011011, eew_e'(w), b, a, '0,
              $sformatf("unknown funct6 eew%0d", 8 << w));
      run_txn(OPIVV, VMULH, eew_e'(w), b, a, '0, $sformatf("opivv eew%0d", 8 << w));
    end
    repeat (2) @(negedge clk);
    assert_errs = vec_mul_unit_i.vec_mul_unit_props_i.prop_errs;
    $display("checks %0d, value errors %0d, handshake errors %0d, assertion errors %0d",
             checks, value_errs, hs_errs, assert_errs);
    if (value_errs == 0 && hs_errs == 0 && assert_errs == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== vec_mul_unit.f ====
hdl/mul_cfg_pkg.sv
hdl/mul_op_pkg.sv
hdl/mul_operand_prep.sv
hdl/mul_lane.sv
hdl/mul_result_collect.sv
hdl/vec_mul_unit.sv
sim/vec_mul_unit_props.sv
sim/vec_mul_unit_tb.sv

// ==== Bender.yml ====
package:
  name: vec_mul_unit

sources:
  - hdl/mul_cfg_pkg.sv
  - hdl/mul_op_pkg.sv
  - hdl/mul_operand_prep.sv
  - hdl/mul_lane.sv
  - hdl/mul_result_collect.sv
  - hdl/vec_mul_unit.sv
  - target: simulation
    files:
      - sim/vec_mul_unit_props.sv
      - sim/vec_mul_unit_tb.sv
